/* rtl/seq_bus_pkg.sv */
package seq_bus_pkg;

    // One register word as seen on the host side of the bus
    typedef logic [31:0] bus_data_t;

    // Word address; the bank decodes the whole byte range
    typedef logic [7:0] bus_addr_t;

    // Access kind carried with every request
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

    // The host holds this request stable for as long as req stays high
    typedef struct packed {
        bus_op_e   op;
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    // Control register with n_steps in bits 7:0 and the burst bit in bit 8
    localparam bus_addr_t ADDR_CONTROL = 8'd0;

    // Timebase divider, one tick every divider plus one clocks
    localparam bus_addr_t ADDR_TIMEBASE = 8'd1;

    // Inter-step delay counted in timebase ticks
    localparam bus_addr_t ADDR_DELAY = 8'd2;

    // First step register
    // Step k sits at ADDR_STEP_BASE plus k and holds a channel number
    localparam bus_addr_t ADDR_STEP_BASE = 8'd3;

endpackage

/* rtl/seq_core_pkg.sv */
package seq_core_pkg;

    // Depth of the step table
    localparam int N_STEPS = 8;

    // Number of start and done line pairs on the channel side
    localparam int N_CHANNELS = 6;

    // Index into the step table
    typedef logic [2:0] step_idx_t;

    // Table entry
    // Values from N_CHANNELS upwards name no channel and mark a skipped step
    typedef logic [3:0] channel_t;

    // Width of the timebase divider and of the delay counter
    typedef logic [15:0] count_t;

    // Complete configuration as held by the register bank
    typedef struct packed {
        logic [7:0]                n_steps;
        logic                      burst;
        count_t                    divider;
        count_t                    delay;
        channel_t [N_STEPS-1:0]    step_table;
    } seq_cfg_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        idle,
        start_step,
        wait_done,
        delay,
        burst_hold
    } seq_state_e;

endpackage

/* rtl/seq_reg_bank.sv */
`timescale 1ns/1ps

module seq_reg_bank (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    req,
    input  seq_bus_pkg::bus_req_t   bus_req,
    output logic                    ack,
    output seq_bus_pkg::bus_data_t  rdata,
    output seq_core_pkg::seq_cfg_t  cfg
);

    seq_core_pkg::seq_cfg_t  cfg_q;
    seq_bus_pkg::bus_data_t  read_word;
    logic [7:0]              step_offset;
    seq_core_pkg::step_idx_t step_sel;
    logic                    is_step;
    logic [7:0]              n_steps_sat;

    // Step registers occupy a contiguous window above the fixed registers
    assign step_offset = bus_req.addr - seq_bus_pkg::ADDR_STEP_BASE;
    assign step_sel    = seq_core_pkg::step_idx_t'(step_offset);
    assign is_step     = (bus_req.addr >= seq_bus_pkg::ADDR_STEP_BASE) &&
                         (step_offset < 8'(seq_core_pkg::N_STEPS));

    // A step count beyond the table depth is clamped to the table depth
    assign n_steps_sat = (bus_req.wdata[7:0] > 8'(seq_core_pkg::N_STEPS)) ?
                         8'(seq_core_pkg::N_STEPS) : bus_req.wdata[7:0];

    // Readback mux; every unmapped word reads as zero
    always_comb begin
        read_word = '0;
        if (is_step) begin
            read_word = seq_bus_pkg::bus_data_t'(cfg_q.step_table[step_sel]);
        end else begin
            case (bus_req.addr)
                seq_bus_pkg::ADDR_CONTROL:  read_word = {23'd0, cfg_q.burst, cfg_q.n_steps};
                seq_bus_pkg::ADDR_TIMEBASE: read_word = {16'd0, cfg_q.divider};
                seq_bus_pkg::ADDR_DELAY:    read_word = {16'd0, cfg_q.delay};
                default:                    read_word = '0;
            endcase
        end
    end

    // Four-phase slave
    // The access happens on the edge that raises ack, and ack then waits for req to fall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b0;
            rdata <= '0;
            cfg_q <= '0;
        end else begin
            if (req && !ack) begin
                ack   <= 1'b1;
                rdata <= read_word;
                if (bus_req.op == seq_bus_pkg::op_write) begin
                    if (is_step) begin
                        cfg_q.step_table[step_sel] <= bus_req.wdata[3:0];
                    end else begin
                        case (bus_req.addr)
                            seq_bus_pkg::ADDR_CONTROL: begin
                                cfg_q.n_steps <= n_steps_sat;
                                cfg_q.burst   <= bus_req.wdata[8];
                            end
                            seq_bus_pkg::ADDR_TIMEBASE: cfg_q.divider <= bus_req.wdata[15:0];
                            seq_bus_pkg::ADDR_DELAY:    cfg_q.delay   <= bus_req.wdata[15:0];
                            // Writes outside the map are dropped
                            default: ;
                        endcase
                    end
                end
            end else if (!req && ack) begin
                // Host has released the request so the handshake closes
                ack <= 1'b0;
            end
        end
    end

    // Configuration is live, a write during a run acts on the next lookup
    assign cfg = cfg_q;

endmodule

/* rtl/seq_step_decoder.sv */
`timescale 1ns/1ps

module seq_step_decoder (
    input  logic                                clock,
    input  logic                                arst_n,
    input  seq_core_pkg::seq_cfg_t              cfg,
    input  seq_core_pkg::step_idx_t             step_index,
    input  logic                                fire,
    input  logic [seq_core_pkg::N_CHANNELS-1:0] step_done,
    output logic                                step_valid,
    output logic                                done_hit,
    output logic [seq_core_pkg::N_CHANNELS-1:0] step_start
);

    seq_core_pkg::channel_t                entry;
    logic [seq_core_pkg::N_CHANNELS-1:0]   channel_onehot;

    // Table lookup for the step the controller is working on
    assign entry = cfg.step_table[step_index];

    // Entries past the last channel are skipped by the controller
    assign step_valid = (entry < seq_core_pkg::channel_t'(seq_core_pkg::N_CHANNELS));

    // One-hot channel select, all zero for an invalid entry
    always_comb begin
        for (int i = 0; i < seq_core_pkg::N_CHANNELS; i++) begin
            channel_onehot[i] = step_valid && (entry == seq_core_pkg::channel_t'(i));
        end
    end

    // Only the done line of the selected channel can end the wait
    assign done_hit = |(step_done & channel_onehot);

    // Start pulse is registered so it lands one clock after the controller fires
    // Fire lasts a single cycle which keeps the pulse to one clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step_start <= '0;
        end else if (fire) begin
            step_start <= channel_onehot;
        end else begin
            step_start <= '0;
        end
    end

endmodule

/* rtl/seq_delay_timer.sv */
`timescale 1ns/1ps

module seq_delay_timer (
    input  logic                   clock,
    input  logic                   arst_n,
    input  seq_core_pkg::seq_cfg_t cfg,
    input  logic                   timer_load,
    output logic                   expired
);

    seq_core_pkg::count_t prescale;
    seq_core_pkg::count_t remaining;
    logic                 tick;
    logic                 counting;

    // The counter only needs the timebase while a delay is still pending
    assign counting = (remaining != '0);

    // Greater-or-equal keeps the prescaler sane if the divider is lowered mid-count
    assign tick = counting && (prescale >= cfg.divider);

    // Timebase prescaler
    // Restarting it on load measures the delay from the load and not from a free-running phase
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prescale <= '0;
        end else if (timer_load || tick) begin
            prescale <= '0;
        end else if (counting) begin
            prescale <= prescale + 1'b1;
        end
    end

    // Delay down-counter in timebase ticks
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
        end else if (timer_load) begin
            remaining <= cfg.delay;
        end else if (tick) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Level output, held until the next load reloads the counter
    // A zero delay therefore shows expired on the first cycle after the load
    assign expired = !counting;

endmodule

/* rtl/seq_controller.sv */
`timescale 1ns/1ps

module seq_controller (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    enable,
    input  seq_core_pkg::seq_cfg_t  cfg,
    input  logic                    step_valid,
    input  logic                    done_hit,
    input  logic                    expired,
    output seq_core_pkg::step_idx_t step_index,
    output logic                    fire,
    output logic                    timer_load,
    output logic                    busy
);

    seq_core_pkg::seq_state_e state;
    seq_core_pkg::seq_state_e next_state;
    seq_core_pkg::step_idx_t  next_index;
    seq_core_pkg::seq_state_e wrap_state;
    logic                     last_step;
    logic                     advance;

    // Treat any index at or past the programmed count as the end of the pass
    // This also covers a step count that shrinks while a run is in progress
    assign last_step = ({5'd0, step_index} + 8'd1) >= cfg.n_steps;

    // Where a finished pass goes next
    always_comb begin
        if (cfg.burst) begin
            wrap_state = seq_core_pkg::burst_hold;
        end else if (enable) begin
            wrap_state = seq_core_pkg::start_step;
        end else begin
            wrap_state = seq_core_pkg::idle;
        end
    end

    // A step is finished after its delay, or at once when its entry is invalid
    assign advance = ((state == seq_core_pkg::start_step) && !step_valid) ||
                     ((state == seq_core_pkg::delay) && expired);

    always_comb begin
        next_state = state;
        next_index = step_index;
        case (state)
            seq_core_pkg::idle: begin
                next_index = '0;
                if (enable && (cfg.n_steps != 8'd0)) begin
                    next_state = seq_core_pkg::start_step;
                end
            end
            seq_core_pkg::start_step: begin
                if (step_valid) begin
                    next_state = seq_core_pkg::wait_done;
                end
            end
            seq_core_pkg::wait_done: begin
                // No timeout here, a silent channel keeps the FSM waiting
                if (done_hit) begin
                    next_state = seq_core_pkg::delay;
                end
            end
            seq_core_pkg::burst_hold: begin
                if (!enable) begin
                    next_state = seq_core_pkg::idle;
                end
            end
            default: ;
        endcase

        // Step advance shared by the invalid-entry skip and the end of a delay
        if (advance) begin
            if (last_step) begin
                next_index = '0;
                next_state = wrap_state;
            end else begin
                next_index = step_index + 1'b1;
                next_state = seq_core_pkg::start_step;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= seq_core_pkg::idle;
            step_index <= '0;
        end else begin
            state      <= next_state;
            step_index <= next_index;
        end
    end

    // The decoder turns this into the registered start pulse
    assign fire = (state == seq_core_pkg::start_step);

    // Load the delay on the cycle that leaves wait_done
    assign timer_load = (state == seq_core_pkg::wait_done) && done_hit;

    assign busy = (state != seq_core_pkg::idle);

endmodule

/* rtl/programmable_sequencer.sv */
`timescale 1ns/1ps

module programmable_sequencer (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic                                req,
    input  seq_bus_pkg::bus_req_t               bus_req,
    output logic                                ack,
    output seq_bus_pkg::bus_data_t              rdata,
    input  logic                                enable,
    input  logic [seq_core_pkg::N_CHANNELS-1:0] step_done,
    output logic [seq_core_pkg::N_CHANNELS-1:0] step_start,
    output logic                                busy
);

    seq_core_pkg::seq_cfg_t  cfg;
    seq_core_pkg::step_idx_t step_index;
    logic                    fire;
    logic                    step_valid;
    logic                    done_hit;
    logic                    timer_load;
    logic                    expired;

    // Host-visible configuration registers
    seq_reg_bank seq_reg_bank_inst (
        .clock   (clock),
        .arst_n  (arst_n),
        .req     (req),
        .bus_req (bus_req),
        .ack     (ack),
        .rdata   (rdata),
        .cfg     (cfg)
    );

    // Step ordering FSM
    seq_controller seq_controller_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .enable     (enable),
        .cfg        (cfg),
        .step_valid (step_valid),
        .done_hit   (done_hit),
        .expired    (expired),
        .step_index (step_index),
        .fire       (fire),
        .timer_load (timer_load),
        .busy       (busy)
    );

    // Channel lookup, start pulse and done select
    seq_step_decoder seq_step_decoder_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .step_index (step_index),
        .fire       (fire),
        .step_done  (step_done),
        .step_valid (step_valid),
        .done_hit   (done_hit),
        .step_start (step_start)
    );

    // Inter-step delay on the divided timebase
    seq_delay_timer seq_delay_timer_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .timer_load (timer_load),
        .expired    (expired)
    );

endmodule

/* verification/seq_sequencer_chk.sv */
`timescale 1ns/1ps

module seq_sequencer_chk (
    input logic                                clock,
    input logic                                arst_n,
    input logic                                req,
    input logic                                ack,
    input logic [seq_core_pkg::N_CHANNELS-1:0] step_start
);

    // Ack only rises in answer to a request the host still holds
    ack_rises_on_req: assert property (@(posedge clock) disable iff (!arst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // Ack only falls once the host has released the request
    ack_falls_on_release: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // At most one channel is started at a time
    start_is_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(step_start))
        else $error("step_start has more than one bit set");

    // Every start pulse is a single clock wide
    start_one_clock: assert property (@(posedge clock) disable iff (!arst_n)
        (|step_start) |=> !(|step_start))
        else $error("step_start stayed high for two clocks");

endmodule

/* verification/programmable_sequencer_tb.sv */
`timescale 1ns/1ps

module programmable_sequencer_tb;

    // Longest runs sum to a few thousand clocks, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    typedef seq_core_pkg::channel_t channel_list_t[$];

    logic                                clock;
    logic                                arst_n;
    logic                                req;
    seq_bus_pkg::bus_req_t               bus_req;
    logic                                ack;
    seq_bus_pkg::bus_data_t              rdata;
    logic                                enable;
    logic [seq_core_pkg::N_CHANNELS-1:0] step_done;
    logic [seq_core_pkg::N_CHANNELS-1:0] step_start;
    logic                                busy;

    logic [15:0]            lfsr_state = 16'd50795;
    seq_core_pkg::channel_t expected_q[$];
    seq_core_pkg::channel_t observed_q[$];
    int                     gap_q[$];
    int                     cycle = 0;
    int                     pulse_count = 0;
    int                     last_done = 0;
    int                     run_start = 0;
    logic                   pending = 1'b0;
    string                  test_name = "reset";

    programmable_sequencer programmable_sequencer_inst (
        .clock(clock), .arst_n(arst_n), .req(req), .bus_req(bus_req), .ack(ack),
        .rdata(rdata), .enable(enable), .step_done(step_done), .step_start(step_start),
        .busy(busy)
    );

    bind programmable_sequencer seq_sequencer_chk seq_sequencer_chk_inst (
        .clock(clock), .arst_n(arst_n), .req(req), .ack(ack), .step_start(step_start)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Galois LFSR with taps x^16+x^14+x^13+x^11+1 that advances one step per bit taken
    function automatic logic random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], random_bit()};
        end
        return value;
    endfunction

    // The reference order lists the valid entries of steps 0 to n_steps-1 once per pass
    function automatic channel_list_t expected_channels(input seq_core_pkg::seq_cfg_t cfg,
                                                        input int passes);
        channel_list_t          order;
        seq_core_pkg::channel_t entry;
        for (int p = 0; p < passes; p++) begin
            for (int k = 0; k < int'(cfg.n_steps); k++) begin
                entry = cfg.step_table[seq_core_pkg::step_idx_t'(k)];
                if (int'(entry) < seq_core_pkg::N_CHANNELS) begin
                    order.push_back(entry);
                end
            end
        end
        return order;
    endfunction

    // Odd steps get unmapped channels 6 to 13 when invalid entries are wanted
    function automatic seq_core_pkg::seq_cfg_t random_config(input int steps, input logic burst,
            input int delay_bits, input int divider_bits, input logic with_invalid);
        seq_core_pkg::seq_cfg_t cfg;
        cfg = '0;
        cfg.n_steps = 8'(steps);
        cfg.burst = burst;
        cfg.delay = seq_core_pkg::count_t'(random_bits(delay_bits));
        cfg.divider = seq_core_pkg::count_t'(random_bits(divider_bits));
        for (int k = 0; k < seq_core_pkg::N_STEPS; k++) begin
            if (with_invalid && (k % 2 == 1)) begin
                cfg.step_table[seq_core_pkg::step_idx_t'(k)] =
                    seq_core_pkg::channel_t'(6 + int'(random_bits(3)));
            end else begin
                cfg.step_table[seq_core_pkg::step_idx_t'(k)] =
                    seq_core_pkg::channel_t'(int'(random_bits(4)) % seq_core_pkg::N_CHANNELS);
            end
        end
        return cfg;
    endfunction

    function automatic int delay_clocks(input seq_core_pkg::seq_cfg_t cfg);
        return int'(cfg.delay) * (int'(cfg.divider) + 1);
    endfunction

    task automatic report_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first failed check");
    endtask

    task automatic check_word(input string name, input seq_bus_pkg::bus_data_t expected,
                              input seq_bus_pkg::bus_data_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_channel(input string name, input seq_core_pkg::channel_t expected,
                                 input seq_core_pkg::channel_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected channel %0d actual channel %0d",
                     name, expected, actual);
            report_failure();
        end
    endtask

    // Every drive from the main process lands 2 ns after a rising edge
    task automatic wait_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #2;
        end
    endtask

    // Four-phase handshake that raises req, waits for ack, drops req and waits for ack to fall
    task automatic bus_transfer(input seq_bus_pkg::bus_op_e op,
                                input seq_bus_pkg::bus_addr_t addr,
                                input seq_bus_pkg::bus_data_t wdata,
                                output seq_bus_pkg::bus_data_t data);
        bus_req = '{op: op, addr: addr, wdata: wdata};
        req = 1'b1;
        do begin
            wait_cycles(1);
        end while (!ack);
        data = rdata;
        req = 1'b0;
        do begin
            wait_cycles(1);
        end while (ack);
    endtask

    task automatic bus_write(input seq_bus_pkg::bus_addr_t addr,
                             input seq_bus_pkg::bus_data_t wdata);
        seq_bus_pkg::bus_data_t ignored;
        bus_transfer(seq_bus_pkg::op_write, addr, wdata, ignored);
    endtask

    task automatic bus_read(input seq_bus_pkg::bus_addr_t addr,
                            output seq_bus_pkg::bus_data_t data);
        bus_transfer(seq_bus_pkg::op_read, addr, '0, data);
    endtask

    task automatic read_expect(input string name, input seq_bus_pkg::bus_addr_t addr,
                               input seq_bus_pkg::bus_data_t expected);
        seq_bus_pkg::bus_data_t value;
        bus_read(addr, value);
        check_word(name, expected, value);
    endtask

    task automatic program_config(input seq_core_pkg::seq_cfg_t cfg);
        bus_write(seq_bus_pkg::ADDR_TIMEBASE, {16'd0, cfg.divider});
        bus_write(seq_bus_pkg::ADDR_DELAY, {16'd0, cfg.delay});
        for (int k = 0; k < seq_core_pkg::N_STEPS; k++) begin
            bus_write(seq_bus_pkg::ADDR_STEP_BASE + 8'(k),
                      {28'd0, cfg.step_table[seq_core_pkg::step_idx_t'(k)]});
        end
        bus_write(seq_bus_pkg::ADDR_CONTROL, {23'd0, cfg.burst, cfg.n_steps});
    endtask

    // Waits for idle, then checks that no pulse is missing and every gap fits the delay
    task automatic finish_run(input seq_core_pkg::seq_cfg_t cfg);
        int span;
        while (busy) begin
            wait_cycles(1);
        end
        wait_cycles(2);
        check_word({test_name, " missing pulses"}, 32'd0, 32'(expected_q.size()));
        span = delay_clocks(cfg);
        foreach (gap_q[i]) begin
            if (gap_q[i] < span || gap_q[i] > span + 4) begin
                $display("** Error: %s gap from done to next start expected %0d to %0d actual %0d",
                         test_name, span, span + 4, gap_q[i]);
                report_failure();
            end
        end
    endtask

    task automatic run_burst(input string name, input seq_core_pkg::seq_cfg_t cfg);
        int base;
        program_config(cfg);
        test_name = name;
        expected_q = expected_channels(cfg, 1);
        gap_q.delete();
        run_start = cycle;
        base = pulse_count + expected_q.size();
        enable = 1'b1;
        while (pulse_count < base || pending) begin
            wait_cycles(1);
        end
        // The last delay and any trailing skipped steps end well inside this window
        // After that the FSM sits in burst_hold
        wait_cycles(delay_clocks(cfg) + 12);
        check_word({name, " busy in burst hold"}, 32'd1, 32'(busy));
        check_word({name, " pulses in one pass"}, 32'(base), 32'(pulse_count));
        enable = 1'b0;
        finish_run(cfg);
    endtask

    task automatic run_continuous(input string name, input seq_core_pkg::seq_cfg_t cfg);
        int per_pass;
        int base;
        program_config(cfg);
        test_name = name;
        expected_q = expected_channels(cfg, 3);
        per_pass = expected_q.size() / 3;
        gap_q.delete();
        run_start = cycle;
        base = pulse_count;
        enable = 1'b1;
        while (pulse_count < base + 2 * per_pass + 1) begin
            wait_cycles(1);
        end
        // Enable drops inside the third pass, so that pass must be the last one
        enable = 1'b0;
        // The FSM has seen enable low by now and must still be working through the pass
        wait_cycles(2);
        check_word({name, " busy after enable drop"}, 32'd1, 32'(busy));
        finish_run(cfg);
        check_word({name, " total pulses"}, 32'(3 * per_pass), 32'(pulse_count - base));
    endtask

    // Fails if the DUT starts a new step while the current channel still owes its done
    task automatic check_no_start(input int channel);
        @(negedge clock);
        if (step_start != '0) begin
            $display("%s: new start pulse before channel %0d returned done",
                     test_name, channel);
            report_failure();
        end
    endtask

    // The done responder answers each start pulse on its own channel after a random latency
    initial begin
        int channel;
        int latency;
        step_done = '0;
        forever begin
            @(negedge clock);
            if (step_start != '0) begin
                channel = $clog2(step_start);
                observed_q.push_back(seq_core_pkg::channel_t'(channel));
                pulse_count++;
                if (last_done >= run_start) begin
                    gap_q.push_back(cycle - last_done);
                end
                pending = 1'b1;
                latency = 1 + int'(random_bits(3));
                repeat (latency) begin
                    check_no_start(channel);
                end
                @(posedge clock);
                #2;
                step_done = {{(seq_core_pkg::N_CHANNELS-1){1'b0}}, 1'b1} << channel;
                // The DUT samples done on the next edge, which is where the gap starts
                check_no_start(channel);
                last_done = cycle + 1;
                pending = 1'b0;
                @(posedge clock);
                #2;
                step_done = '0;
            end
        end
    end

    // The comparer pulls observed channels against the reference order
    initial begin
        forever begin
            @(posedge clock);
            while (observed_q.size() != 0) begin
                if (expected_q.size() == 0) begin
                    $display("%s: start pulse on channel %0d beyond the expected order",
                             test_name, observed_q[0]);
                    report_failure();
                end
                check_channel(test_name, expected_q.pop_front(), observed_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    initial begin
        seq_bus_pkg::bus_data_t value;
        arst_n = 1'b0;
        req = 1'b0;
        bus_req = '0;
        enable = 1'b0;
        repeat (8) @(posedge clock);
        #2;
        arst_n = 1'b1;
        // All registers are zero here, so enable alone must not start a run
        enable = 1'b1;
        wait_cycles(4);
        check_word("idle with zero steps", 32'd0, 32'(busy));
        enable = 1'b0;

        test_name = "register readback";
        value = random_bits(32);
        bus_write(seq_bus_pkg::ADDR_TIMEBASE, value);
        read_expect("timebase readback", seq_bus_pkg::ADDR_TIMEBASE, {16'd0, value[15:0]});
        value = random_bits(32);
        bus_write(seq_bus_pkg::ADDR_DELAY, value);
        read_expect("delay readback", seq_bus_pkg::ADDR_DELAY, {16'd0, value[15:0]});
        for (int k = 0; k < seq_core_pkg::N_STEPS; k++) begin
            value = random_bits(32);
            bus_write(seq_bus_pkg::ADDR_STEP_BASE + 8'(k), value);
            read_expect("step readback", seq_bus_pkg::ADDR_STEP_BASE + 8'(k),
                        {28'd0, value[3:0]});
        end
        value = random_bits(32);
        value[7:0] = 8'(random_bits(3));
        bus_write(seq_bus_pkg::ADDR_CONTROL, value);
        read_expect("control readback", seq_bus_pkg::ADDR_CONTROL, {23'd0, value[8:0]});
        // A step count past the table depth reads back as the depth
        value = random_bits(32);
        value[7:0] = 8'd9 + 8'(random_bits(7));
        bus_write(seq_bus_pkg::ADDR_CONTROL, value);
        read_expect("step count saturation", seq_bus_pkg::ADDR_CONTROL,
                    {23'd0, value[8], 8'd8});
        bus_write(8'd11, random_bits(32));
        read_expect("unmapped word 11", 8'd11, 32'd0);
        bus_write(8'd200, random_bits(32));
        read_expect("unmapped word 200", 8'd200, 32'd0);

        run_burst("channel order", random_config(8, 1'b1, 2, 1, 1'b0));
        run_burst("invalid entries", random_config(8, 1'b1, 2, 1, 1'b1));
        for (int r = 0; r < 3; r++) begin
            run_burst("delay length", random_config(2 + int'(random_bits(3)) % 7, 1'b1, 4, 3,
                                                    1'b0));
        end
        run_continuous("continuous mode", random_config(3 + int'(random_bits(1)), 1'b0, 2, 1,
                                                        1'b0));

        if (expected_q.size() == 0 && observed_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Start pulses were left unmatched at the end of the run");
            report_failure();
        end
    end

endmodule

/* project.f */
rtl/seq_bus_pkg.sv
rtl/seq_core_pkg.sv
rtl/seq_reg_bank.sv
rtl/seq_step_decoder.sv
rtl/seq_delay_timer.sv
rtl/seq_controller.sv
rtl/programmable_sequencer.sv
verification/seq_sequencer_chk.sv
verification/programmable_sequencer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
        --top-module programmable_sequencer_tb \
        -f project.f --Mdir obj_dir -o sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
